//--- design/gambit_consts.svh
// gambit decode front constants: opcode map, instruction field positions and widths
`ifndef GAMBIT_CONSTS_SVH
`define GAMBIT_CONSTS_SVH

// ==================================================
// widths
// ==================================================
`define INSTR_W 52
`define CONST_W 52
`define OPC_W 7
`define TAG_W 8
`define MSZ_W 3

// immediate fields all start at bit 17
`define IMM_LO 17
`define C8_HI 24
`define C22_HI 38
`define C35_HI 51
// branch displacement sits in the top 12 bits
`define DISP_HI 51
`define DISP_LO 40
// indexed memory select for the 8-bit displacement forms
`define ONE_BIT 16

// memory access sizes
`define MSZ_BYTE 3'd0
`define MSZ_WORD 3'd1

// ==================================================
// opcodes
// ==================================================
// register-register forms, the low nibble picks the operation
`define ADD_3R 7'h04
`define SUB_3R 7'h05
`define CMP_3R 7'h06
`define CMPU_3R 7'h07
`define AND_3R 7'h08
`define OR_3R 7'h09
`define DIV_3R 7'h0C
`define CSR 7'h0F
// 22-bit immediate forms
`define ADD_RI22 7'h14
`define SUB_RI22 7'h15
`define CMP_RI22 7'h16
`define CMPU_RI22 7'h17
`define AND_RI22 7'h18
`define OR_RI22 7'h19
// 35-bit immediate forms
`define ADD_RI35 7'h24
`define SUB_RI35 7'h25
`define CMP_RI35 7'h26
`define CMPU_RI35 7'h27
`define AND_RI35 7'h28
`define OR_RI35 7'h29
// flow control
`define JAL 7'h30
`define JAL_RN 7'h31
`define BRANCH0 7'h32
`define BRANCH1 7'h33
`define BRKGRP 7'h38
`define RETGRP 7'h39
`define STPGRP 7'h3A
// memory, bit 0 selects byte size, bit 3 selects store
`define LD_D8 7'h40
`define LDB_D8 7'h41
`define ST_D8 7'h48
`define STB_D8 7'h49
`define LD_D22 7'h50
`define LDB_D22 7'h51
`define ST_D22 7'h58
`define STB_D22 7'h59
`define LD_D35 7'h60
`define LDB_D35 7'h61
`define ST_D35 7'h68
`define STB_D35 7'h69

`endif

//--- design/gambitPkg.sv
// gambit decode front types: instruction formats, fetch item and decode bundle
`include "gambit_consts.svh"

package gambitPkg;

	// generic view, opcode in the low bits
	typedef struct packed
	{
		logic [`INSTR_W-`OPC_W-1:0] rest;
		logic [`OPC_W-1:0] opcode;
	} GenFmt;

	// 8-bit displacement memory and 3R forms
	typedef struct packed
	{
		logic [`INSTR_W-`C8_HI-2:0] upper;
		logic [`C8_HI-`IMM_LO:0] const8;
		logic one;
		logic [`ONE_BIT-`OPC_W-1:0] mid;
		logic [`OPC_W-1:0] opcode;
	} Ri8Fmt;

	// conditional branch, displacement at the top
	typedef struct packed
	{
		logic [`DISP_HI-`DISP_LO:0] disp;
		logic [`DISP_LO-`OPC_W-1:0] rest;
		logic [`OPC_W-1:0] opcode;
	} BrFmt;

	// jump and link through a register
	typedef struct packed
	{
		logic [`C35_HI-`IMM_LO:0] tgt;
		logic [`IMM_LO-`OPC_W-1:0] regs;
		logic [`OPC_W-1:0] opcode;
	} JalRnFmt;

	// one raw word, decoded per format
	typedef union packed
	{
		GenFmt gen;
		Ri8Fmt ri8;
		BrFmt br;
		JalRnFmt jalrn;
	} Instruction;

	typedef struct packed
	{
		Instruction instr;
		logic [`TAG_W-1:0] tag;
	} FetchItem;

	// constant, tag, then the classification flags
	typedef struct packed
	{
		logic [`CONST_W-1:0] constant;
		logic [`TAG_W-1:0] tag;
		logic isAlu;
		logic isAlu0;
		logic isCmp;
		logic isFlowCtrl;
		logic isLoad;
		logic isStore;
		logic isMem;
		logic isMemNdx;
		logic [`MSZ_W-1:0] memSize;
		logic isJal;
		logic isBranch;
		logic isBrkGrp;
		logic isRetGrp;
		logic writesReg;
	} DecodeBundle;

endpackage

//--- design/fetchStage.sv
// fetch stage: four-phase input port feeding a one-entry holding register
module fetchStage
	import gambitPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     inReq,
	input  FetchItem inItem,
	output logic     inAck,
	input  logic     decHold,
	output logic     fetchValid,
	output FetchItem fetchItem
);
	// bit 0 is the acknowledge, so inAck comes straight off a flop
	localparam logic [1:0] ST_IDLE = 2'b00;
	localparam logic [1:0] ST_CAPTURED = 2'b01;
	localparam logic [1:0] ST_WAIT_RELEASE = 2'b10;

	logic [1:0] state;
	// request as sampled on the last edge
	logic reqSeen;
	logic full;
	logic capture;
	logic leaving;

	// entry drains when the decoder takes it
	assign leaving = full && !decHold;
	// only an empty entry takes a new word, and only once per request
	assign capture = reqSeen && !full && (state != ST_CAPTURED);

	assign inAck = state[0];
	assign fetchValid = full;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= ST_IDLE;
			reqSeen <= 1'b0;
			full <= 1'b0;
		end
		else
		begin
			reqSeen <= inReq;
			case (state)
				ST_IDLE:
					if (capture)
						state <= ST_CAPTURED;
					else if (reqSeen)
						state <= ST_WAIT_RELEASE;
				// request pending, entry still occupied downstream
				ST_WAIT_RELEASE:
					if (capture)
						state <= ST_CAPTURED;
				// ack high until the producer withdraws
				ST_CAPTURED:
					if (!reqSeen)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
			if (capture)
				full <= 1'b1;
			else if (leaving)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			fetchItem <= inItem;
	end

	// ack only ever answers a request already on the port
	assert property (@(posedge clk) disable iff (!rstN) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose while inReq was low");

endmodule

//--- design/instrDecoder.sv
// instruction decoder: classifies the opcode and extracts the constant into the decode stage
`include "gambit_consts.svh"

module instrDecoder
	import gambitPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        fetchValid,
	input  FetchItem    fetchItem,
	output logic        decHold,
	input  logic        issueHold,
	output logic        decValid,
	output DecodeBundle decBundle
);
	logic full;
	logic accept;
	DecodeBundle decoded;

	// ==================================================
	// classification
	// ==================================================
	// cmp and csr count as alu work too
	function automatic logic isAluOp(input Instruction isn);
		return isn.gen.opcode inside {`ADD_3R, `ADD_RI22, `ADD_RI35, `SUB_3R, `SUB_RI22,
			`SUB_RI35, `AND_3R, `AND_RI22, `AND_RI35, `OR_3R, `OR_RI22, `OR_RI35,
			`CMP_3R, `CMP_RI22, `CMP_RI35, `CMPU_3R, `CMPU_RI22, `CMPU_RI35, `DIV_3R, `CSR};
	endfunction

	// only alu0 has the divider and csr access
	function automatic logic isAlu0Op(input Instruction isn);
		return isn.gen.opcode inside {`DIV_3R, `CSR};
	endfunction

	function automatic logic isCmpOp(input Instruction isn);
		return isn.gen.opcode inside {`CMP_3R, `CMP_RI22, `CMP_RI35,
			`CMPU_3R, `CMPU_RI22, `CMPU_RI35};
	endfunction

	function automatic logic isFlowOp(input Instruction isn);
		return isn.gen.opcode inside {`JAL, `JAL_RN, `BRANCH0, `BRANCH1,
			`BRKGRP, `RETGRP, `STPGRP};
	endfunction

	function automatic logic isLoadOp(input Instruction isn);
		return isn.gen.opcode inside {`LD_D8, `LD_D22, `LD_D35, `LDB_D8, `LDB_D22, `LDB_D35};
	endfunction

	function automatic logic isStoreOp(input Instruction isn);
		return isn.gen.opcode inside {`ST_D8, `ST_D22, `ST_D35, `STB_D8, `STB_D22, `STB_D35};
	endfunction

	// indexed addressing exists only in the 8-bit displacement forms
	function automatic logic isMemNdxOp(input Instruction isn);
		if (isn.ri8.opcode inside {`LD_D8, `LDB_D8, `ST_D8, `STB_D8})
			return ~isn.ri8.one;
		return 1'b0;
	endfunction

	// non-memory ops report word size as well
	function automatic logic [`MSZ_W-1:0] memSizeOf(input Instruction isn);
		if (isn.gen.opcode inside {`LDB_D8, `LDB_D22, `LDB_D35, `STB_D8, `STB_D22, `STB_D35})
			return `MSZ_BYTE;
		return `MSZ_WORD;
	endfunction

	function automatic logic isJalOp(input Instruction isn);
		return isn.gen.opcode == `JAL || isn.jalrn.opcode == `JAL_RN;
	endfunction

	// predictable branches only
	function automatic logic isBranchOp(input Instruction isn);
		return isn.br.opcode inside {`BRANCH0, `BRANCH1};
	endfunction

	// unknown opcodes fall through as register writers
	function automatic logic writesRegOp(input Instruction isn);
		return !(isn.gen.opcode inside {`STPGRP, `BRANCH0, `BRANCH1, `ST_D8, `ST_D22,
			`ST_D35, `STB_D8, `STB_D22, `STB_D35});
	endfunction

	// ==================================================
	// constant extraction
	// ==================================================
	function automatic logic hasConst8(input Instruction isn);
		return isn.gen.opcode inside {`ADD_3R, `SUB_3R, `AND_3R, `OR_3R, `CMP_3R, `CMPU_3R,
			`LD_D8, `LDB_D8, `ST_D8, `STB_D8};
	endfunction

	function automatic logic hasConst22(input Instruction isn);
		return isn.gen.opcode inside {`ADD_RI22, `SUB_RI22, `AND_RI22, `OR_RI22, `CMP_RI22,
			`CMPU_RI22, `LD_D22, `LDB_D22, `ST_D22, `STB_D22};
	endfunction

	// priority is branch disp, then const8, then const22, else const35
	function automatic logic [`CONST_W-1:0] extractConst(input Instruction isn);
		logic [`INSTR_W-1:0] raw;
		raw = isn;
		if (isBranchOp(isn))
			return {{(`CONST_W-`DISP_HI+`DISP_LO-1){isn.br.disp[`DISP_HI-`DISP_LO]}},
				isn.br.disp};
		if (hasConst8(isn))
			return {{(`CONST_W-`C8_HI+`IMM_LO-1){isn.ri8.const8[`C8_HI-`IMM_LO]}},
				isn.ri8.const8};
		if (hasConst22(isn))
			return {{(`CONST_W-`C22_HI+`IMM_LO-1){raw[`C22_HI]}}, raw[`C22_HI:`IMM_LO]};
		return {{(`CONST_W-`C35_HI+`IMM_LO-1){raw[`C35_HI]}}, raw[`C35_HI:`IMM_LO]};
	endfunction

	always_comb
	begin
		decoded.constant = extractConst(fetchItem.instr);
		decoded.tag = fetchItem.tag;
		decoded.isAlu = isAluOp(fetchItem.instr);
		decoded.isAlu0 = isAlu0Op(fetchItem.instr);
		decoded.isCmp = isCmpOp(fetchItem.instr);
		decoded.isFlowCtrl = isFlowOp(fetchItem.instr);
		decoded.isLoad = isLoadOp(fetchItem.instr);
		decoded.isStore = isStoreOp(fetchItem.instr);
		decoded.isMem = isLoadOp(fetchItem.instr) || isStoreOp(fetchItem.instr);
		decoded.isMemNdx = isMemNdxOp(fetchItem.instr);
		decoded.memSize = memSizeOf(fetchItem.instr);
		decoded.isJal = isJalOp(fetchItem.instr);
		decoded.isBranch = isBranchOp(fetchItem.instr);
		decoded.isBrkGrp = fetchItem.instr.gen.opcode == `BRKGRP;
		decoded.isRetGrp = fetchItem.instr.gen.opcode == `RETGRP;
		decoded.writesReg = writesRegOp(fetchItem.instr);
	end

	// ==================================================
	// decode stage register
	// ==================================================
	// full and stuck behind the issue stage
	assign decHold = full && issueHold;
	assign accept = fetchValid && !decHold;
	assign decValid = full;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (!issueHold)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			decBundle <= decoded;
	end

	assert property (@(posedge clk) disable iff (!rstN)
		decValid |-> !(decBundle.isLoad && decBundle.isStore))
		else $error("decoded bundle is both load and store");

endmodule

//--- design/issueStage.sv
// issue stage: output holding register driving the four-phase issue port
module issueStage
	import gambitPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        decValid,
	input  DecodeBundle decBundle,
	output logic        issueHold,
	output logic        outReq,
	output DecodeBundle outBundle,
	input  logic        outAck
);
	// bit 0 is the request, kept glitch free off the state flop
	localparam logic [1:0] ST_EMPTY = 2'b00;
	localparam logic [1:0] ST_REQUESTING = 2'b01;
	localparam logic [1:0] ST_RELEASING = 2'b10;

	logic [1:0] state;
	logic released;
	logic load;

	// consumer has dropped ack, the handshake is complete this edge
	assign released = (state == ST_RELEASING) && !outAck;
	// a finished release frees the entry for a same-edge reload
	assign issueHold = (state != ST_EMPTY) && !released;
	assign load = decValid && !issueHold;
	assign outReq = state[0];

	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= ST_EMPTY;
		else
		begin
			case (state)
				ST_EMPTY:
					if (load)
						state <= ST_REQUESTING;
				ST_REQUESTING:
					if (outAck)
						state <= ST_RELEASING;
				// wait for ack low before the next request
				ST_RELEASING:
					if (released)
						state <= load ? ST_REQUESTING : ST_EMPTY;
				default:
					state <= ST_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			outBundle <= decBundle;
	end

	// bundle holds still across the request phase
	assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outBundle))
		else $error("outBundle changed while outReq was high");

	// request only withdrawn once the consumer has acked
	assert property (@(posedge clk) disable iff (!rstN) $fell(outReq) |-> $past(outAck))
		else $error("outReq dropped before outAck");

endmodule

//--- design/decodeTop.sv
// decode front top: fetch, decode and issue stages between two four-phase ports
module decodeTop
	import gambitPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        inReq,
	input  FetchItem    inItem,
	output logic        inAck,
	output logic        outReq,
	output DecodeBundle outBundle,
	input  logic        outAck
);
	// fetch to decode link
	logic fetchValid;
	FetchItem fetchItem;
	logic decHold;
	// decode to issue link
	logic decValid;
	DecodeBundle decBundle;
	logic issueHold;

	fetchStage uFetch
	(
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inItem(inItem),
		.inAck(inAck),
		.decHold(decHold),
		.fetchValid(fetchValid),
		.fetchItem(fetchItem)
	);

	instrDecoder uDecode
	(
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchItem(fetchItem),
		.decHold(decHold),
		.issueHold(issueHold),
		.decValid(decValid),
		.decBundle(decBundle)
	);

	issueStage uIssue
	(
		.clk(clk),
		.rstN(rstN),
		.decValid(decValid),
		.decBundle(decBundle),
		.issueHold(issueHold),
		.outReq(outReq),
		.outBundle(outBundle),
		.outAck(outAck)
	);

endmodule

//--- sim/decodeRef.svh
// decode reference model: expected bundle per instruction word and the random opcode pool
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// ==================================================
// opcode pool
// ==================================================
localparam logic [`OPC_W-1:0] OPC_POOL [39] = '{
	`ADD_3R, `SUB_3R, `CMP_3R, `CMPU_3R, `AND_3R, `OR_3R, `DIV_3R, `CSR,
	`ADD_RI22, `SUB_RI22, `CMP_RI22, `CMPU_RI22, `AND_RI22, `OR_RI22,
	`ADD_RI35, `SUB_RI35, `CMP_RI35, `CMPU_RI35, `AND_RI35, `OR_RI35,
	`JAL, `JAL_RN, `BRANCH0, `BRANCH1, `BRKGRP, `RETGRP, `STPGRP,
	`LD_D8, `LDB_D8, `ST_D8, `STB_D8, `LD_D22, `LDB_D22, `ST_D22, `STB_D22,
	`LD_D35, `LDB_D35, `ST_D35, `STB_D35
};

// mostly listed opcodes, now and then one from the empty 0x7x block
function automatic logic [`OPC_W-1:0] pickOpcode();
	if ($urandom_range(9) == 0)
		return {3'b111, 4'($urandom)};
	return OPC_POOL[6'($urandom_range(38))];
endfunction

// low w bits of v, sign extended to the full constant width
function automatic logic [`CONST_W-1:0] signExtend(input logic [`CONST_W-1:0] v, input int w);
	logic signed [`CONST_W-1:0] s;
	s = $signed(v << (`CONST_W - w));
	return s >>> (`CONST_W - w);
endfunction

// ==================================================
// reference decode
// ==================================================
function automatic DecodeBundle refDecode(input logic [`INSTR_W-1:0] word,
	input logic [`TAG_W-1:0] tag);
	DecodeBundle b;
	logic [`OPC_W-1:0] opc;
	int cw;
	opc = word[`OPC_W-1:0];
	b = '0;
	b.tag = tag;
	b.writesReg = 1'b1;
	b.memSize = `MSZ_WORD;
	// 35-bit field unless the form says otherwise
	cw = 35;
	case (opc)
		`ADD_3R, `SUB_3R, `AND_3R, `OR_3R:
		begin
			b.isAlu = 1'b1;
			cw = 8;
		end
		`CMP_3R, `CMPU_3R:
		begin
			b.isAlu = 1'b1;
			b.isCmp = 1'b1;
			cw = 8;
		end
		// divide and csr keep the wide field
		`DIV_3R, `CSR:
		begin
			b.isAlu = 1'b1;
			b.isAlu0 = 1'b1;
		end
		`ADD_RI22, `SUB_RI22, `AND_RI22, `OR_RI22:
		begin
			b.isAlu = 1'b1;
			cw = 22;
		end
		`CMP_RI22, `CMPU_RI22:
		begin
			b.isAlu = 1'b1;
			b.isCmp = 1'b1;
			cw = 22;
		end
		`ADD_RI35, `SUB_RI35, `AND_RI35, `OR_RI35:
			b.isAlu = 1'b1;
		`CMP_RI35, `CMPU_RI35:
		begin
			b.isAlu = 1'b1;
			b.isCmp = 1'b1;
		end
		`JAL, `JAL_RN:
		begin
			b.isFlowCtrl = 1'b1;
			b.isJal = 1'b1;
		end
		`BRANCH0, `BRANCH1:
		begin
			b.isFlowCtrl = 1'b1;
			b.isBranch = 1'b1;
			b.writesReg = 1'b0;
		end
		`BRKGRP:
		begin
			b.isFlowCtrl = 1'b1;
			b.isBrkGrp = 1'b1;
		end
		`RETGRP:
		begin
			b.isFlowCtrl = 1'b1;
			b.isRetGrp = 1'b1;
		end
		`STPGRP:
		begin
			b.isFlowCtrl = 1'b1;
			b.writesReg = 1'b0;
		end
		// indexed only when the one bit is clear
		`LD_D8, `LDB_D8:
		begin
			b.isLoad = 1'b1;
			b.isMemNdx = !word[`ONE_BIT];
			cw = 8;
		end
		`ST_D8, `STB_D8:
		begin
			b.isStore = 1'b1;
			b.isMemNdx = !word[`ONE_BIT];
			cw = 8;
		end
		`LD_D22, `LDB_D22:
		begin
			b.isLoad = 1'b1;
			cw = 22;
		end
		`ST_D22, `STB_D22:
		begin
			b.isStore = 1'b1;
			cw = 22;
		end
		`LD_D35, `LDB_D35:
			b.isLoad = 1'b1;
		`ST_D35, `STB_D35:
			b.isStore = 1'b1;
		default:
			cw = 35;
	endcase
	b.isMem = b.isLoad || b.isStore;
	if (b.isStore)
		b.writesReg = 1'b0;
	// odd memory opcodes are the byte forms
	if (b.isMem && opc[0])
		b.memSize = `MSZ_BYTE;
	if (b.isBranch)
		b.constant = signExtend(word >> `DISP_LO, `DISP_HI - `DISP_LO + 1);
	else
		b.constant = signExtend(word >> `IMM_LO, cw);
	return b;
endfunction

`endif

//--- sim/decodeTb.sv
// decode front testbench: random producer and slow consumer around the decode top
`include "gambit_consts.svh"

module decodeTb
	import gambitPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ITEMS = 200;
	// 200 items at 20 cycles worst case, plus margin
	localparam int CYCLE_LIMIT = 6000;
	localparam int FLAG_W = $bits(DecodeBundle) - `CONST_W - `TAG_W;

	logic clk;
	logic rstN;
	logic inReq;
	FetchItem inItem;
	logic inAck;
	logic outReq;
	DecodeBundle outBundle;
	logic outAck;

	// expected bundles of captured items, oldest first
	DecodeBundle expectQ[$];
	int recvCount;
	int cycleCount;
	logic anySent;

	`include "decodeRef.svh"

	decodeTop DUT
	(
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inItem(inItem),
		.inAck(inAck),
		.outReq(outReq),
		.outBundle(outBundle),
		.outAck(outAck)
	);

	initial
		clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run aborted");
	endtask

	task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp)
			else abortRun($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	// ==================================================
	// producer and consumer
	// ==================================================
	task automatic sendItem(input logic [`TAG_W-1:0] tag);
		FetchItem item;
		logic [`INSTR_W-1:0] word;
		word[31:0] = $urandom;
		word[`INSTR_W-1:32] = 20'($urandom);
		word[`OPC_W-1:0] = pickOpcode();
		item.instr = word;
		item.tag = tag;
		inItem = item;
		inReq = 1'b1;
		anySent = 1'b1;
		@(negedge clk);
		while (!inAck)
			@(negedge clk);
		// captured, so now outstanding
		expectQ.push_back(refDecode(word, tag));
		inReq = 1'b0;
		@(negedge clk);
		while (inAck)
			@(negedge clk);
	endtask

	task automatic produce();
		for (int i = 0; i < NUM_ITEMS; i++)
		begin
			sendItem(8'(i));
			repeat ($urandom_range(3)) @(negedge clk);
		end
	endtask

	// oldest outstanding item must be the one on the port
	task automatic checkBundle();
		DecodeBundle exp;
		if (expectQ.size() == 0)
			abortRun("outReq raised with no item outstanding");
		else
		begin
			exp = expectQ.pop_front();
			checkField("outBundle.tag", 64'(outBundle.tag), 64'(exp.tag));
			checkField("outBundle.constant", 64'(outBundle.constant), 64'(exp.constant));
			checkField("outBundle flags", 64'(outBundle[FLAG_W-1:0]), 64'(exp[FLAG_W-1:0]));
			recvCount++;
		end
	endtask

	task automatic consume();
		repeat (NUM_ITEMS)
		begin
			@(negedge clk);
			while (!outReq)
				@(negedge clk);
			// slow ack builds back-pressure
			repeat ($urandom_range(6)) @(negedge clk);
			checkBundle();
			outAck = 1'b1;
			@(negedge clk);
			while (outReq)
				@(negedge clk);
			outAck = 1'b0;
		end
	endtask

	initial
	begin
		void'($urandom(54127));
		rstN = 1'b0;
		inReq = 1'b0;
		inItem = '0;
		outAck = 1'b0;
		anySent = 1'b0;
		recvCount = 0;
		cycleCount = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		assert (!inAck && !outReq)
			else abortRun("inAck or outReq high right after reset");
		// idle cycles before the first request
		repeat (4) @(negedge clk);
		fork
			produce();
			consume();
		join
		if (expectQ.size() == 0 && recvCount == NUM_ITEMS)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
			abortRun("items still outstanding at the end of the run");
	end

	// ==================================================
	// protocol checks and timeout
	// ==================================================
	assert property (@(posedge clk) disable iff (!rstN) !anySent |-> !outReq && !inAck)
		else abortRun("outReq or inAck high before any item was sent");
	assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outBundle))
		else abortRun("outBundle changed while outReq was high");
	assert property (@(posedge clk) disable iff (!rstN) $rose(outReq) |-> !$past(outAck))
		else abortRun("new outReq raised while outAck was still high");
	// ack answers a pending request, and falls only after release
	assert property (@(posedge clk) disable iff (!rstN) $rose(inAck) |-> $past(inReq))
		else abortRun("inAck rose without a pending inReq");
	assert property (@(posedge clk) disable iff (!rstN) $fell(inAck) |-> !$past(inReq))
		else abortRun("inAck fell while inReq was still high");

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
			abortRun($sformatf("timeout after %0d cycles", cycleCount));
		else
		begin
			// one per stage at most
			assert (expectQ.size() <= 3)
				else abortRun("more than three items in flight, inAck was not withheld");
		end
	end

endmodule

//--- filelist.f
+incdir+design
+incdir+sim
design/gambitPkg.sv
design/fetchStage.sv
design/instrDecoder.sv
design/issueStage.sv
design/decodeTop.sv
sim/decodeTb.sv

//--- run.sh
#!/bin/sh
# build the decode front testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decodeTb -f filelist.f
# exit status of the simulation is the verdict
./obj_dir/VdecodeTb
